//--- design/issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire tomasulo_pkg::issue_word_t              instr_i,
    input  wire logic                                   issue_i,
    output logic                                        stall_o,
    input  wire logic [tomasulo_pkg::NUM_STATIONS-1:0]  station_busy_i,
    output logic [tomasulo_pkg::NUM_STATIONS-1:0]       station_load_o,
    output tomasulo_pkg::rs_entry_t                     entry_o,
    input  wire logic                                   rob_full_i,
    input  wire logic [tomasulo_pkg::TAG_W-1:0]         rob_tail_i,
    output logic                                        rob_alloc_o,
    output logic [tomasulo_pkg::REG_ADDR_W-1:0]         alloc_rd_o,
    output logic [tomasulo_pkg::TAG_W-1:0]              query_tag_a_o,
    output logic [tomasulo_pkg::TAG_W-1:0]              query_tag_b_o,
    input  wire tomasulo_pkg::operand_t                 query_a_i,
    input  wire tomasulo_pkg::operand_t                 query_b_i,
    input  wire tomasulo_pkg::cdb_t                     cdb_i,
    input  wire tomasulo_pkg::rf_write_t                rf_write_i
);
    import tomasulo_pkg::*;

    logic [XLEN-1:0]   rf_data_q [NUM_REGS];
    logic              rf_busy_q [NUM_REGS];
    logic [TAG_W-1:0]  rf_tag_q  [NUM_REGS];

    logic [NUM_STATIONS-1:0] free_onehot;
    logic                    accept;

    // data bus first, then the reorder buffer, else wait on the tag
    function automatic operand_t resolve(
        input logic [REG_ADDR_W-1:0] idx,
        input logic                  busy,
        input logic [TAG_W-1:0]      tag,
        input logic [XLEN-1:0]       value,
        input operand_t              rob_q,
        input cdb_t                  bus
    );
        operand_t opnd;
        opnd = '{ready: 1'b1, tag: '0, data: value};
        if (idx == '0) begin
            opnd.data = '0;
        end else if (busy) begin
            opnd.tag = tag;
            if (bus.valid && bus.tag == tag) begin
                opnd.data = bus.data;
            end else if (rob_q.ready) begin
                opnd.data = rob_q.data;
            end else begin
                opnd.ready = 1'b0;
            end
        end
        return opnd;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // station select and handshake
    ////////////////////////////////////////////////////////////////////

    // lowest free station
    always_comb begin
        free_onehot = '0;
        for (int i = 0; i < NUM_STATIONS; i++) begin
            if (!station_busy_i[i] && free_onehot == '0) begin
                free_onehot[i] = 1'b1;
            end
        end
    end

    assign stall_o        = (free_onehot == '0) || rob_full_i;
    assign accept         = issue_i && !stall_o;
    assign station_load_o = accept ? free_onehot : '0;
    assign rob_alloc_o    = accept;
    assign alloc_rd_o     = instr_i.rd;

    assign query_tag_a_o = rf_tag_q[instr_i.rs1];
    assign query_tag_b_o = rf_tag_q[instr_i.rs2];

    always_comb begin
        entry_o.op       = instr_i.op;
        entry_o.dest_tag = rob_tail_i;
        entry_o.src_a    = resolve(instr_i.rs1, rf_busy_q[instr_i.rs1], rf_tag_q[instr_i.rs1],
                                   rf_data_q[instr_i.rs1], query_a_i, cdb_i);
        if (instr_i.use_imm) begin
            entry_o.src_b = '{ready: 1'b1, tag: '0, data: instr_i.imm};
        end else begin
            entry_o.src_b = resolve(instr_i.rs2, rf_busy_q[instr_i.rs2],
                                    rf_tag_q[instr_i.rs2], rf_data_q[instr_i.rs2],
                                    query_b_i, cdb_i);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // register file with rename tags
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                rf_busy_q[r] <= 1'b0;
                rf_tag_q[r]  <= '0;
                rf_data_q[r] <= '0;
            end
        end else begin
            // retire write clears the tag only for its own producer
            if (rf_write_i.valid && rf_write_i.commit.rd != '0) begin
                rf_data_q[rf_write_i.commit.rd] <= rf_write_i.commit.data;
                if (rf_tag_q[rf_write_i.commit.rd] == rf_write_i.tag) begin
                    rf_busy_q[rf_write_i.commit.rd] <= 1'b0;
                end
            end
            // a new rename wins over a same-cycle retire
            if (accept && instr_i.rd != '0) begin
                rf_busy_q[instr_i.rd] <= 1'b1;
                rf_tag_q[instr_i.rd]  <= rob_tail_i;
            end
        end
    end

    // the chosen station must report busy from the next cycle
    a_load_onehot: assert property (@(posedge clk) disable iff (reset_i)
        station_load_o != '0 |-> !stall_o && $onehot(station_load_o)
            ##1 (station_busy_i & $past(station_load_o)) != '0)
        else $error("station load while stalled, not one-hot or not taken");

endmodule

`default_nettype wire

//--- design/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                                         clk,
    input  wire logic                                         reset_i,
    input  wire logic                                         rob_alloc_i,
    input  wire logic [tomasulo_pkg::REG_ADDR_W-1:0]          alloc_rd_i,
    output logic                                              rob_full_o,
    output logic [tomasulo_pkg::TAG_W-1:0]                    rob_tail_o,
    input  wire logic [tomasulo_pkg::TAG_W-1:0]               query_tag_a_i,
    input  wire logic [tomasulo_pkg::TAG_W-1:0]               query_tag_b_i,
    output tomasulo_pkg::operand_t                            query_a_o,
    output tomasulo_pkg::operand_t                            query_b_o,
    input  wire tomasulo_pkg::cdb_t [tomasulo_pkg::NUM_STATIONS-1:0] req_i,
    output logic [tomasulo_pkg::NUM_STATIONS-1:0]             grant_o,
    output tomasulo_pkg::cdb_t                                cdb_o,
    output tomasulo_pkg::rf_write_t                           rf_write_o,
    output logic                                              commit_valid_o,
    output tomasulo_pkg::commit_t                             commit_o
);
    import tomasulo_pkg::*;

    logic [TAG_W-1:0]       head_q;
    logic [TAG_W-1:0]       tail_q;
    logic [TAG_W:0]         count_q;

    logic                   ready_q [ROB_DEPTH];
    logic [REG_ADDR_W-1:0]  rd_q    [ROB_DEPTH];
    logic [XLEN-1:0]        data_q  [ROB_DEPTH];

    logic                   commit_fire;

    function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
        if (ptr == TAG_W'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign rob_full_o = (count_q == (TAG_W + 1)'(ROB_DEPTH));
    assign rob_tail_o = tail_q;

    // operand lookup for renamed sources
    assign query_a_o = '{ready: ready_q[query_tag_a_i], tag: query_tag_a_i,
                         data: data_q[query_tag_a_i]};
    assign query_b_o = '{ready: ready_q[query_tag_b_i], tag: query_tag_b_i,
                         data: data_q[query_tag_b_i]};

    ////////////////////////////////////////////////////////////////////
    // data bus arbitration
    ////////////////////////////////////////////////////////////////////

    // fixed priority with the lowest station first
    always_comb begin
        grant_o = '0;
        cdb_o   = '0;
        for (int i = 0; i < NUM_STATIONS; i++) begin
            if (req_i[i].valid && grant_o == '0) begin
                grant_o[i] = 1'b1;
                cdb_o      = req_i[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // in-order retire
    ////////////////////////////////////////////////////////////////////

    assign commit_fire    = (count_q != '0) && ready_q[head_q];
    assign commit_valid_o = commit_fire;
    assign commit_o       = '{rd: rd_q[head_q], data: data_q[head_q]};
    assign rf_write_o     = '{valid: commit_fire, tag: head_q, commit: commit_o};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int e = 0; e < ROB_DEPTH; e++) begin
                ready_q[e] <= 1'b0;
            end
        end else begin
            if (rob_alloc_i) begin
                ready_q[tail_q] <= 1'b0;
                tail_q          <= next_ptr(tail_q);
            end
            // result lands one edge after its broadcast
            if (cdb_o.valid) begin
                ready_q[cdb_o.tag] <= 1'b1;
            end
            if (commit_fire) begin
                head_q <= next_ptr(head_q);
            end
            count_q <= count_q + (TAG_W + 1)'(rob_alloc_i) - (TAG_W + 1)'(commit_fire);
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (rob_alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (cdb_o.valid) begin
            data_q[cdb_o.tag] <= cdb_o.data;
        end
    end

    // each entry is broadcast once, while it is still waiting
    a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(grant_o) && (!cdb_o.valid || !ready_q[cdb_o.tag]))
        else $error("more than one station granted or result broadcast twice");

    a_alloc_not_full: assert property (@(posedge clk) disable iff (reset_i)
        rob_alloc_i |-> !rob_full_o)
        else $error("allocation into a full reorder buffer");

endmodule

`default_nettype wire

//--- design/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  wire logic                     clk,
    input  wire logic                     reset_i,
    input  wire logic                     load_i,
    input  wire tomasulo_pkg::rs_entry_t  entry_i,
    input  wire tomasulo_pkg::cdb_t       cdb_i,
    input  wire logic                     grant_i,
    output logic                          busy_o,
    output tomasulo_pkg::cdb_t            result_o
);
    import tomasulo_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } rs_state_e;

    rs_state_e        state_q;
    rs_entry_t        entry_q;
    logic [XLEN-1:0]  result_q;
    logic             operands_ready;

    // fill a pending operand from a matching bus beat
    function automatic operand_t snoop(input operand_t opnd, input cdb_t bus);
        operand_t upd;
        upd = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            upd.ready = 1'b1;
            upd.data  = bus.data;
        end
        return upd;
    endfunction

    function automatic logic [XLEN-1:0] alu(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [SHAMT_W-1:0] shamt;
        shamt = b[SHAMT_W-1:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << shamt;
            SRL:     return a >> shamt;
            SRA:     return $unsigned($signed(a) >>> shamt);
            SLT:     return XLEN'($signed(a) < $signed(b));
            SLTU:    return XLEN'(a < b);
            default: return '0;
        endcase
    endfunction

    assign operands_ready = entry_q.src_a.ready && entry_q.src_b.ready;

    ////////////////////////////////////////////////////////////////////
    // entry control
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (load_i) state_q <= WAIT;
                WAIT: if (operands_ready) state_q <= DONE;
                DONE: if (grant_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // entry payload and held result
    always_ff @(posedge clk) begin
        if (load_i) begin
            entry_q <= entry_i;
        end else if (state_q == WAIT) begin
            entry_q.src_a <= snoop(entry_q.src_a, cdb_i);
            entry_q.src_b <= snoop(entry_q.src_b, cdb_i);
        end
        if (state_q == WAIT && operands_ready) begin
            result_q <= alu(entry_q.op, entry_q.src_a.data, entry_q.src_b.data);
        end
    end

    assign busy_o = (state_q != IDLE);

    // request held until the reorder buffer grants it
    assign result_o = '{valid: (state_q == DONE), tag: entry_q.dest_tag, data: result_q};

    a_no_load_busy: assert property (@(posedge clk) disable iff (reset_i)
        load_i |-> state_q == IDLE)
        else $error("station loaded while busy");

endmodule

`default_nettype wire

//--- design/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire tomasulo_pkg::issue_word_t  instr_i,
    input  wire logic                       issue_i,
    output logic                            stall_o,
    output logic                            commit_valid_o,
    output tomasulo_pkg::commit_t           commit_o
);
    import tomasulo_pkg::*;

    logic [NUM_STATIONS-1:0]  station_busy;
    logic [NUM_STATIONS-1:0]  station_load;
    logic [NUM_STATIONS-1:0]  grant;
    cdb_t [NUM_STATIONS-1:0]  req;
    rs_entry_t                entry;
    cdb_t                     cdb;

    logic                     rob_full;
    logic                     rob_alloc;
    logic [TAG_W-1:0]         rob_tail;
    logic [REG_ADDR_W-1:0]    alloc_rd;
    logic [TAG_W-1:0]         query_tag_a;
    logic [TAG_W-1:0]         query_tag_b;
    operand_t                 query_a;
    operand_t                 query_b;
    rf_write_t                rf_write;

    issue_unit u_issue (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_i        (instr_i),
        .issue_i        (issue_i),
        .stall_o        (stall_o),
        .station_busy_i (station_busy),
        .station_load_o (station_load),
        .entry_o        (entry),
        .rob_full_i     (rob_full),
        .rob_tail_i     (rob_tail),
        .rob_alloc_o    (rob_alloc),
        .alloc_rd_o     (alloc_rd),
        .query_tag_a_o  (query_tag_a),
        .query_tag_b_o  (query_tag_b),
        .query_a_i      (query_a),
        .query_b_i      (query_b),
        .cdb_i          (cdb),
        .rf_write_i     (rf_write)
    );

    // identical stations sharing the dispatch word and the bus
    for (genvar i = 0; i < NUM_STATIONS; i++) begin : g_station
        reservation_station u_rs (
            .clk      (clk),
            .reset_i  (reset_i),
            .load_i   (station_load[i]),
            .entry_i  (entry),
            .cdb_i    (cdb),
            .grant_i  (grant[i]),
            .busy_o   (station_busy[i]),
            .result_o (req[i])
        );
    end

    reorder_buffer u_rob (
        .clk            (clk),
        .reset_i        (reset_i),
        .rob_alloc_i    (rob_alloc),
        .alloc_rd_i     (alloc_rd),
        .rob_full_o     (rob_full),
        .rob_tail_o     (rob_tail),
        .query_tag_a_i  (query_tag_a),
        .query_tag_b_i  (query_tag_b),
        .query_a_o      (query_a),
        .query_b_o      (query_b),
        .req_i          (req),
        .grant_o        (grant),
        .cdb_o          (cdb),
        .rf_write_o     (rf_write),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

`default_nettype wire

//--- design/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    ////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////

    localparam int NUM_STATIONS = 4;
    localparam int ROB_DEPTH    = 8;
    localparam int TAG_W        = 3;
    localparam int XLEN         = 32;
    localparam int NUM_REGS     = 32;
    localparam int REG_ADDR_W   = 5;
    // shift amount taken from the low bits of operand b
    localparam int SHAMT_W      = $clog2(XLEN);

    ////////////////////////////////////////////////////////////////////
    // opcodes and bundles
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU
    } alu_op_e;

    // decoded word from the caller
    typedef struct packed {
        alu_op_e                 op;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;
        logic [REG_ADDR_W-1:0]   rs2;
        logic                    use_imm;
        logic [XLEN-1:0]         imm;
    } issue_word_t;

    // tag is only meaningful while ready is low
    typedef struct packed {
        logic                    ready;
        logic [TAG_W-1:0]        tag;
        logic [XLEN-1:0]         data;
    } operand_t;

    typedef struct packed {
        alu_op_e                 op;
        operand_t                src_a;
        operand_t                src_b;
        logic [TAG_W-1:0]        dest_tag;
    } rs_entry_t;

    // common data bus beat and a station's result request
    typedef struct packed {
        logic                    valid;
        logic [TAG_W-1:0]        tag;
        logic [XLEN-1:0]         data;
    } cdb_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]   rd;
        logic [XLEN-1:0]         data;
    } commit_t;

    // retire write back into the register file
    typedef struct packed {
        logic                    valid;
        logic [TAG_W-1:0]        tag;
        commit_t                 commit;
    } rf_write_t;

endpackage

`default_nettype wire

//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////
// in-order architectural model
////////////////////////////////////////////////////////////////////////

logic [XLEN-1:0] arch_rf [NUM_REGS];
commit_t         expect_q [$];

function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
    if (idx == '0) begin
        return '0;
    end
    return arch_rf[idx];
endfunction

function automatic logic [XLEN-1:0] expected_result(
    input alu_op_e         op,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
);
    logic [4:0]      sh;
    logic [XLEN-1:0] fill;
    logic            lt_s;
    logic            lt_u;
    sh   = b[4:0];
    // sign bits shifted in from the top for SRA
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    // flipping the sign bits turns a signed compare into an unsigned one
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    lt_u = a < b;
    case (op)
        ADD:     return a + b;
        SUB:     return a + ~b + 32'd1;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLL:     return a << sh;
        SRL:     return a >> sh;
        SRA:     return (a >> sh) | fill;
        SLT:     return {{(XLEN-1){1'b0}}, lt_s};
        SLTU:    return {{(XLEN-1){1'b0}}, lt_u};
        default: return '0;
    endcase
endfunction

task automatic execute_word(input issue_word_t w);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    a   = read_reg(w.rs1);
    b   = w.use_imm ? w.imm : read_reg(w.rs2);
    res = expected_result(w.op, a, b);
    if (w.rd != '0) begin
        arch_rf[w.rd] = res;
    end
    expect_q.push_back('{rd: w.rd, data: res});
endtask

task automatic clear_model();
    for (int r = 0; r < NUM_REGS; r++) begin
        arch_rf[r] = '0;
    end
    expect_q.delete();
endtask

task automatic check_commit(input commit_t got, input commit_t exp);
    if (got.rd !== exp.rd) begin
        abort_run($sformatf("[FAIL] %0t ns commit_o.rd got %0d expected %0d",
                            $time, got.rd, exp.rd));
    end else if (got.data !== exp.data) begin
        abort_run($sformatf("[FAIL] %0t ns commit_o.data got %08h expected %08h",
                            $time, got.data, exp.data));
    end
endtask

task automatic check_stall(input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t ns stall_o got %b expected %b", $time, got, exp));
    end
endtask

`endif

//--- dv/tb_tomasulo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo;
    import tomasulo_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_CYCLES     = 4;
    localparam int NUM_WORDS       = 400;
    localparam int DRAIN_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = NUM_WORDS * 20 + RESET_CYCLES;

    logic        clk;
    logic        reset_i;
    issue_word_t instr_i;
    logic        issue_i;
    logic        stall_o;
    logic        commit_valid_o;
    commit_t     commit_o;

    int          accepted;
    int          committed;
    int          stall_cycles;
    logic        pending;
    logic        burst;

    `include "tb_model.svh"

    tomasulo_core DUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_i        (instr_i),
        .issue_i        (issue_i),
        .stall_o        (stall_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout, %0d of %0d words committed", committed, accepted));
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////////////
    // random program words
    ////////////////////////////////////////////////////////////////////

    // mostly x0..x7 so that words depend on each other
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        if ($urandom_range(7) == 0) begin
            return REG_ADDR_W'($urandom_range(31));
        end
        return REG_ADDR_W'($urandom_range(7));
    endfunction

    function automatic logic [XLEN-1:0] pick_imm();
        case ($urandom_range(3))
            0:       return XLEN'($urandom_range(31));
            1:       return ~XLEN'($urandom_range(31));
            2:       return ($urandom_range(1) == 0) ? 32'h8000_0000 : 32'h7fff_ffff;
            default: return XLEN'($urandom());
        endcase
    endfunction

    function automatic issue_word_t make_word();
        issue_word_t w;
        w.op      = alu_op_e'(4'($urandom_range(9)));
        w.rd      = pick_reg();
        w.rs1     = pick_reg();
        w.rs2     = pick_reg();
        w.use_imm = ($urandom_range(1) == 1);
        w.imm     = pick_imm();
        return w;
    endfunction

    // outputs are sampled at the falling edge, before new inputs go out
    task automatic sample_commit();
        commit_t exp;
        if (commit_valid_o) begin
            if (expect_q.size() == 0) begin
                abort_run($sformatf("commit at %0t ns with no accepted word outstanding",
                                    $time));
            end else begin
                exp = expect_q.pop_front();
                check_commit(commit_o, exp);
                committed++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hf813c256));
        reset_i      = 1'b1;
        issue_i      = 1'b0;
        instr_i      = '0;
        pending      = 1'b0;
        burst        = 1'b0;
        accepted     = 0;
        committed    = 0;
        stall_cycles = 0;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        // quiet core after reset
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_stall(stall_o, 1'b0);
            sample_commit();
        end

        // alternate sparse traffic with back-to-back bursts
        while (accepted < NUM_WORDS) begin
            @(negedge clk);
            sample_commit();
            burst = ((accepted / 64) % 2) == 1;
            if (!pending && (burst || $urandom_range(1) == 0)) begin
                instr_i = make_word();
                pending = 1'b1;
            end
            issue_i = pending;
            // stall_o holds until the next rising edge
            if (stall_o) begin
                stall_cycles++;
            end else if (pending) begin
                execute_word(instr_i);
                accepted++;
                pending = 1'b0;
            end
        end

        @(negedge clk);
        sample_commit();
        issue_i = 1'b0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            sample_commit();
        end

        // no stray commits once drained
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            sample_commit();
        end
        check_stall(stall_o, 1'b0);

        if (stall_cycles != 0) begin
            $display("%0d words committed, %0d stall cycles", committed, stall_cycles);
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("stall_o never rose during the bursts");
        end
    end

endmodule

`default_nettype wire

//--- files.f
design/tomasulo_pkg.sv
design/issue_unit.sv
design/reservation_station.sv
design/reorder_buffer.sv
design/tomasulo_core.sv
+incdir+dv
dv/tb_tomasulo.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tomasulo \
    -f files.f -o sim_tomasulo > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tomasulo > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || grep -q "Testbench passed" sim.log
